// File: sdcard_vip.f
rtl/sdcard_vip_pkg.sv
rtl/sdcard_crc7.sv
rtl/sdcard_cmdio.sv
rtl/sdcard_cmd_handler.sv
rtl/sdcard_vip_top.sv
bench/sdcard_vip_tb.sv

// File: Makefile
# Verilator flow for the SD card VIP
# Override any variable on the command line, e.g. make sim BUILD_DIR=out

VERILATOR ?= verilator
TOP       ?= sdcard_vip_tb
FILELIST  ?= sdcard_vip.f
BUILD_DIR ?= build
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The simulator exit status carries the test result
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/sdcard_vip_tb.sv
//########################################
// SD card VIP testbench
// Host side of the CMD line: sends frames,
// captures responses and checks them
// against a reference card model
//########################################

`timescale 1ns/1ps

module sdcard_vip_tb
    import sdcard_vip_pkg::*;
;

    localparam int RESP_LIMIT    = 200;
    localparam int RELEASE_LIMIT = 10;

    logic i_clk;
    logic i_nrst;
    logic i_cmd;
    logic o_cmd;
    logic o_cmd_dir;

    // Reference copy of the card state and the app-command flag
    logic [3:0] ref_state;
    logic       ref_app;

    sdcard_vip_top dut0 (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_cmd     (i_cmd),
        .o_cmd     (o_cmd),
        .o_cmd_dir (o_cmd_dir)
    );

    always #50 i_clk = ~i_clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    // Polynomial x^7 + x^3 + 1, MSB first, register starts at zero
    function automatic crc7_t crc7_bits(input logic [39:0] data);
        crc7_t crc;
        logic  fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = crc[6] ^ data[i];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    function automatic cmd_arg_t status_word(input logic [3:0] st, input logic app,
                                             input logic illegal);
        cmd_arg_t word;
        word = '0;
        word[R1_STATE_LSB +: 4] = st;
        word[R1_APP_BIT]        = app;
        word[R1_ILLEGAL_BIT]    = illegal;
        return word;
    endfunction

    // Expected payload for one command; also steps the reference card state
    function automatic cmd_arg_t expected_payload(input cmd_index_t idx, input cmd_arg_t arg);
        cmd_arg_t word;
        logic     app_before;
        app_before = ref_app;
        ref_app    = 1'b0;
        word       = '0;
        if (idx == CMD_GO_IDLE) begin
            ref_state = IDLE;
        end else if (idx == CMD_SEND_RCA) begin
            ref_state   = STBY;
            word        = status_word(STBY, app_before, 1'b0);
            word[31:16] = CARD_RCA;
        end else if (idx == CMD_IF_COND) begin
            word[11:0] = arg[11:0];
        end else if (idx == CMD_APP) begin
            word    = status_word(ref_state, 1'b1, 1'b0);
            ref_app = 1'b1;
        end else if (idx == ACMD_OP_COND && app_before) begin
            ref_state = READY;
            word      = OCR_READY;
        end else begin
            word = status_word(ref_state, app_before, 1'b1);
        end
        return word;
    endfunction

    task automatic send_frame(input cmd_index_t idx, input cmd_arg_t arg,
                              input logic bad_crc, input logic tx_bit);
        logic [39:0] head;
        crc7_t       crc;
        frame_t      frame;
        int          i;
        head = {1'b0, tx_bit, idx, arg};
        crc  = crc7_bits(head);
        if (bad_crc) begin
            crc[0] = ~crc[0];
        end
        frame = {head, crc, 1'b1};
        for (i = 47; i >= 0; i--) begin
            @(negedge i_clk);
            i_cmd = frame[i];
        end
    endtask

    // Bits are taken at the falling edge, in the middle of each card bit
    task automatic capture_response(output frame_t resp);
        int waited;
        int i;
        waited = 0;
        resp   = '1;
        @(negedge i_clk);
        while (!(o_cmd_dir == 1'b0 && o_cmd == 1'b0)) begin
            waited++;
            if (waited > RESP_LIMIT) begin
                fail_run("Timeout: the card sent no response start bit");
            end
            @(negedge i_clk);
        end
        resp[47] = o_cmd;
        for (i = 46; i >= 0; i--) begin
            @(negedge i_clk);
            if (o_cmd_dir !== 1'b0) begin
                fail_run("The card released the CMD line in the middle of a response");
            end
            resp[i] = o_cmd;
        end
    endtask

    task automatic wait_line_release();
        int waited;
        waited = 0;
        @(negedge i_clk);
        while (o_cmd_dir !== 1'b1) begin
            waited++;
            if (waited > RELEASE_LIMIT) begin
                fail_run("Timeout: the card did not release the CMD line");
            end
            @(negedge i_clk);
        end
        repeat (2) @(negedge i_clk);
    endtask

    task automatic run_exchange(input string name, input cmd_index_t idx,
                                input cmd_arg_t arg);
        cmd_arg_t exp;
        frame_t   resp;
        exp = expected_payload(idx, arg);
        send_frame(idx, arg, 1'b0, 1'b1);
        capture_response(resp);
        check_value({name, " start bit"}, 32'd0, 32'(resp[47]));
        check_value({name, " tx bit"}, 32'd0, 32'(resp[46]));
        check_value({name, " index"}, 32'(idx), 32'(resp[45:40]));
        check_value({name, " payload"}, exp, resp[39:8]);
        check_value({name, " crc7"}, 32'(crc7_bits(resp[47:8])), 32'(resp[7:1]));
        check_value({name, " end bit"}, 32'd1, 32'(resp[0]));
        wait_line_release();
    endtask

    // A dropped frame gives one cycle of turnaround, then a silent card
    task automatic check_rejected(input string name, input logic bad_crc,
                                  input logic tx_bit);
        cmd_arg_t arg;
        int       i;
        arg = $urandom;
        send_frame(CMD_IF_COND, arg, bad_crc, tx_bit);
        repeat (2) @(negedge i_clk);
        for (i = 0; i < 100; i++) begin
            check_value({name, " cmd_dir"}, 32'd1, 32'(o_cmd_dir));
            check_value({name, " cmd"}, 32'd1, 32'(o_cmd));
            @(negedge i_clk);
        end
    endtask

    initial begin
        cmd_index_t cmd_pool [6];
        int         i;
        cmd_index_t idx;
        cmd_arg_t   arg;
        i_clk     = 1'b0;
        i_nrst    = 1'b0;
        i_cmd     = 1'b1;
        ref_state = IDLE;
        ref_app   = 1'b0;
        cmd_pool  = '{6'd0, 6'd3, 6'd8, 6'd17, 6'd41, 6'd55};
        void'($urandom(82866));

        repeat (10) @(negedge i_clk);
        i_nrst = 1'b1;

        for (i = 0; i < INIT_CLKS + 1; i++) begin
            @(negedge i_clk);
            check_value("power-up cmd_dir", 32'd1, 32'(o_cmd_dir));
            check_value("power-up cmd", 32'd1, 32'(o_cmd));
        end

        run_exchange("cmd0", CMD_GO_IDLE, 32'h0);
        arg = $urandom;
        run_exchange("cmd8", CMD_IF_COND, arg);

        run_exchange("cmd55", CMD_APP, 32'h0);
        run_exchange("acmd41", ACMD_OP_COND, 32'h40FF8000);
        run_exchange("cmd41 without cmd55", ACMD_OP_COND, 32'h40FF8000);

        run_exchange("cmd3", CMD_SEND_RCA, 32'h0);
        run_exchange("cmd17", 6'd17, 32'h0000_0200);

        check_rejected("bad crc", 1'b1, 1'b1);
        check_rejected("bad tx bit", 1'b0, 1'b0);
        arg = $urandom;
        run_exchange("cmd8 after reject", CMD_IF_COND, arg);

        for (i = 0; i < 40; i++) begin
            idx = cmd_pool[$urandom % 6];
            arg = $urandom;
            run_exchange($sformatf("random %0d cmd%0d", i, idx), idx, arg);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: rtl/sdcard_vip_top.sv
//########################################
// SD card VIP top level
// CMD line engine, CRC7 unit and command
// handler joined together
//########################################

`timescale 1ns/1ps

module sdcard_vip_top
    import sdcard_vip_pkg::*;
(
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_cmd,
    output logic o_cmd,
    output logic o_cmd_dir
);

    logic       crc_clear;
    logic       crc_next;
    logic       crc_dat;
    crc7_t      crc7;
    logic       req_valid;
    logic       req_ready;
    cmd_index_t req_cmd;
    cmd_arg_t   req_arg;
    logic       resp_valid;
    logic       resp_ready;
    cmd_arg_t   resp_data;

    sdcard_cmdio cmdio0 (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_cmd        (i_cmd),
        .o_cmd        (o_cmd),
        .o_cmd_dir    (o_cmd_dir),
        .o_crc_clear  (crc_clear),
        .o_crc_next   (crc_next),
        .o_crc_dat    (crc_dat),
        .i_crc7       (crc7),
        .o_req_valid  (req_valid),
        .o_req_cmd    (req_cmd),
        .o_req_arg    (req_arg),
        .i_req_ready  (req_ready),
        .i_resp_valid (resp_valid),
        .i_resp_data  (resp_data),
        .o_resp_ready (resp_ready)
    );

    sdcard_crc7 crc0 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (crc_dat),
        .o_crc7  (crc7)
    );

    sdcard_cmd_handler hnd0 (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (req_valid),
        .i_req_cmd    (req_cmd),
        .i_req_arg    (req_arg),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp_data  (resp_data),
        .i_resp_ready (resp_ready)
    );

endmodule

// File: rtl/sdcard_cmd_handler.sv
//########################################
// SD card command handler
// Small card-state model that picks the
// 32-bit response word for each command
//########################################

`timescale 1ns/1ps

module sdcard_cmd_handler
    import sdcard_vip_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_req_valid,
    input  cmd_index_t i_req_cmd,
    input  cmd_arg_t   i_req_arg,
    output logic       o_req_ready,
    output logic       o_resp_valid,
    output cmd_arg_t   o_resp_data,
    input  logic       i_resp_ready
);

    card_state_t card_state;
    card_state_t next_state;
    logic        app_flag;
    logic        app_next;
    logic        busy;
    logic        resp_pend;
    logic        build;
    cmd_index_t  cmd_q;
    cmd_arg_t    arg_q;
    cmd_arg_t    resp_word;
    cmd_arg_t    rca_status;

    function automatic cmd_arg_t r1_word(card_state_t st, logic app, logic illegal);
        cmd_arg_t w;
        w = '0;
        w[R1_STATE_LSB +: 4] = st;
        w[R1_APP_BIT]        = app;
        w[R1_ILLEGAL_BIT]    = illegal;
        return w;
    endfunction

    // Status words report the state the card is in after this command
    always_comb begin
        next_state = card_state;
        app_next   = 1'b0;
        rca_status = r1_word(STBY, app_flag, 1'b0);
        case (cmd_q)
            CMD_GO_IDLE: begin
                next_state = IDLE;
                resp_word  = '0;
            end
            CMD_SEND_RCA: begin
                next_state = STBY;
                resp_word  = {CARD_RCA, rca_status[15:0]};
            end
            CMD_IF_COND: begin
                resp_word = {20'h0, arg_q[11:0]};
            end
            CMD_APP: begin
                app_next  = 1'b1;
                resp_word = r1_word(card_state, 1'b1, 1'b0);
            end
            ACMD_OP_COND: begin
                if (app_flag) begin
                    next_state = READY;
                    resp_word  = OCR_READY;
                end else begin
                    resp_word = r1_word(card_state, 1'b0, 1'b1);
                end
            end
            default: begin
                resp_word = r1_word(card_state, app_flag, 1'b1);
            end
        endcase
    end

    // One cycle of decode between accepting a request and offering the answer
    assign build = busy && !resp_pend && !o_resp_valid;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            card_state   <= IDLE;
            app_flag     <= 1'b0;
            busy         <= 1'b0;
            resp_pend    <= 1'b0;
            o_req_ready  <= 1'b0;
            o_resp_valid <= 1'b0;
        end else begin
            if (o_req_ready && i_req_valid) begin
                o_req_ready <= 1'b0;
                busy        <= 1'b1;
            end else if (!busy) begin
                o_req_ready <= 1'b1;
            end
            if (build) begin
                resp_pend  <= 1'b1;
                card_state <= next_state;
                app_flag   <= app_next;
            end
            if (resp_pend) begin
                resp_pend    <= 1'b0;
                o_resp_valid <= 1'b1;
            end
            if (o_resp_valid && i_resp_ready) begin
                o_resp_valid <= 1'b0;
                busy         <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_req_ready && i_req_valid) begin
            cmd_q <= i_req_cmd;
            arg_q <= i_req_arg;
        end
        if (build) begin
            o_resp_data <= resp_word;
        end
    end

    // A pending response is held unchanged until the engine takes it
    a_resp_hold: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_resp_valid && !i_resp_ready) |=> (o_resp_valid && $stable(o_resp_data))
    );

endmodule

// File: rtl/sdcard_cmdio.sv
//########################################
// SD card CMD line engine
// Receives 48-bit host frames, checks the
// CRC7, passes the command on and sends
// back a 48-bit response frame
//########################################

`timescale 1ns/1ps

module sdcard_cmdio
    import sdcard_vip_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_cmd,
    output logic       o_cmd,
    output logic       o_cmd_dir,
    output logic       o_crc_clear,
    output logic       o_crc_next,
    output logic       o_crc_dat,
    input  crc7_t      i_crc7,
    output logic       o_req_valid,
    output cmd_index_t o_req_cmd,
    output cmd_arg_t   o_req_arg,
    input  logic       i_req_ready,
    input  logic       i_resp_valid,
    input  cmd_arg_t   i_resp_data,
    output logic       o_resp_ready
);

    cmdio_state_t state;
    logic [6:0]   clk_cnt;
    bit_cnt_t     bit_cnt;
    frame_t       rx_shift;
    frame_t       tx_shift;
    crc7_t        crc_calc;
    logic         cmd_dir;
    logic         cmdz;
    logic         req_valid;

    assign o_resp_ready = (state == WAIT_RESP);

    // CRC control
    // On transmit the CRC is fed one bit ahead of the line, so the full
    // 40-bit result is ready when the last payload bit goes out
    always_comb begin
        o_crc_clear = 1'b0;
        o_crc_next  = 1'b0;
        o_crc_dat   = i_cmd;
        case (state)
            INIT, REQ_STOPBIT: begin
                o_crc_clear = 1'b1;
            end
            REQ_STARTBIT: begin
                if (cmdz && !i_cmd) begin
                    o_crc_next = 1'b1;
                end else begin
                    o_crc_clear = 1'b1;
                end
            end
            REQ_TXBIT, REQ_CMD, REQ_ARG: begin
                o_crc_next = 1'b1;
            end
            WAIT_RESP: begin
                // Response start bit
                o_crc_next = i_resp_valid;
                o_crc_dat  = 1'b0;
            end
            RESP: begin
                o_crc_next = (bit_cnt != '0);
                o_crc_dat  = tx_shift[46];
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= INIT;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            tx_shift  <= '1;
            cmd_dir   <= 1'b1;
            cmdz      <= 1'b1;
            req_valid <= 1'b0;
        end else begin
            if (req_valid && i_req_ready) begin
                req_valid <= 1'b0;
            end

            // Previous line level, whichever side drove it
            cmdz     <= cmd_dir ? i_cmd : tx_shift[47];
            tx_shift <= {tx_shift[46:0], 1'b1};

            case (state)
                INIT: begin
                    clk_cnt <= clk_cnt + 7'd1;
                    if (clk_cnt == 7'(INIT_CLKS)) begin
                        state <= REQ_STARTBIT;
                    end
                end
                REQ_STARTBIT: begin
                    if (cmdz && !i_cmd) begin
                        state <= REQ_TXBIT;
                    end
                end
                REQ_TXBIT: begin
                    state   <= REQ_CMD;
                    bit_cnt <= 6'd5;
                end
                REQ_CMD: begin
                    if (bit_cnt == '0) begin
                        state   <= REQ_ARG;
                        bit_cnt <= 6'd31;
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                REQ_ARG: begin
                    if (bit_cnt == '0) begin
                        state   <= REQ_CRC7;
                        bit_cnt <= 6'd6;
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                REQ_CRC7: begin
                    if (bit_cnt == '0) begin
                        state <= REQ_STOPBIT;
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                REQ_STOPBIT: begin
                    state   <= REQ_VALID;
                    cmd_dir <= 1'b0;
                end
                REQ_VALID: begin
                    // Bad frames are dropped silently and the line is released
                    if (rx_shift[46] && (crc_calc == rx_shift[7:1])) begin
                        state     <= WAIT_RESP;
                        req_valid <= 1'b1;
                    end else begin
                        state   <= REQ_STARTBIT;
                        cmd_dir <= 1'b1;
                    end
                end
                WAIT_RESP: begin
                    if (i_resp_valid) begin
                        state    <= RESP;
                        bit_cnt  <= 6'd39;
                        tx_shift <= {2'b00, rx_shift[45:40], i_resp_data, 8'hFF};
                    end
                end
                RESP: begin
                    if (bit_cnt == '0) begin
                        state    <= RESP_CRC7;
                        bit_cnt  <= 6'd6;
                        // CRC first, then the end bit and idle ones behind it
                        tx_shift <= {i_crc7, {41{1'b1}}};
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                RESP_CRC7: begin
                    if (bit_cnt == '0) begin
                        state <= RESP_STOPBIT;
                    end else begin
                        bit_cnt <= bit_cnt - 6'd1;
                    end
                end
                RESP_STOPBIT: begin
                    state   <= REQ_STARTBIT;
                    cmd_dir <= 1'b1;
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    // Frame capture and the CRC computed over it
    always_ff @(posedge i_clk) begin
        if (state < REQ_VALID) begin
            rx_shift <= {rx_shift[46:0], i_cmd};
        end
        if (state == REQ_STOPBIT) begin
            crc_calc <= i_crc7;
        end
    end

    assign o_cmd       = tx_shift[47];
    assign o_cmd_dir   = cmd_dir;
    assign o_req_valid = req_valid;
    assign o_req_cmd   = rx_shift[45:40];
    assign o_req_arg   = rx_shift[39:8];

    // The card never pulls the line low while it is listening
    a_listen_high: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_cmd_dir |-> o_cmd
    );

    // A request only leaves after a checked frame
    a_req_from_valid: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        $rose(o_req_valid) |-> ($past(state) == REQ_VALID)
    );

endmodule

// File: rtl/sdcard_crc7.sv
//########################################
// SD CRC7 generator
// Serial LFSR for x^7 + x^3 + 1, one bit
// per enabled cycle
//########################################

`timescale 1ns/1ps

module sdcard_crc7
    import sdcard_vip_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_nrst,
    input  logic  i_clear,
    input  logic  i_next,
    input  logic  i_dat,
    output crc7_t o_crc7
);

    crc7_t crc;
    logic  feedback;

    // Incoming bit against the register MSB decides whether the polynomial is folded in
    assign feedback = crc[6] ^ i_dat;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc <= '0;
        end else if (i_clear) begin
            crc <= '0;
        end else if (i_next) begin
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

    assign o_crc7 = crc;

endmodule

// File: rtl/sdcard_vip_pkg.sv
//########################################
// SD card VIP shared definitions
// Field widths, engine and card state
// encodings and protocol constants used by
// the CMD line model
//########################################

package sdcard_vip_pkg;

    // Widths of the CMD frame fields
    typedef logic [5:0]  cmd_index_t;
    typedef logic [31:0] cmd_arg_t;
    typedef logic [6:0]  crc7_t;
    typedef logic [47:0] frame_t;
    typedef logic [5:0]  bit_cnt_t;

    // Receive states come first, so a compare against REQ_VALID splits rx from tx
    typedef enum logic [3:0] {
        INIT,
        REQ_STARTBIT,
        REQ_TXBIT,
        REQ_CMD,
        REQ_ARG,
        REQ_CRC7,
        REQ_STOPBIT,
        REQ_VALID,
        WAIT_RESP,
        RESP,
        RESP_CRC7,
        RESP_STOPBIT
    } cmdio_state_t;

    // Codes follow the CURRENT_STATE field of the SD card status
    typedef enum logic [3:0] {
        IDLE  = 4'd0,
        READY = 4'd1,
        STBY  = 4'd3
    } card_state_t;

    localparam int INIT_CLKS = 70;

    localparam cmd_index_t CMD_GO_IDLE  = 6'd0;
    localparam cmd_index_t CMD_SEND_RCA = 6'd3;
    localparam cmd_index_t CMD_IF_COND  = 6'd8;
    localparam cmd_index_t CMD_APP      = 6'd55;
    localparam cmd_index_t ACMD_OP_COND = 6'd41;

    localparam cmd_arg_t    OCR_READY = 32'hC0FF8000;
    localparam logic [15:0] CARD_RCA  = 16'h1234;

    localparam int R1_ILLEGAL_BIT = 22;
    localparam int R1_APP_BIT     = 5;
    localparam int R1_STATE_LSB   = 9;

endpackage
